// File: design/rename_cfg_pkg.sv
package rename_cfg_pkg;

  // --------------------------------------------------------------------------
  // group and register file sizes
  // --------------------------------------------------------------------------
  localparam int DISP_SIZE    = 2;
  localparam int ARCH_REG_W   = 5;
  localparam int ARCH_REG_NUM = 32;

  // ids per free list, one list per dispatch slot
  localparam int FLIST_SIZE = 16;

  // 32 identity ids plus DISP_SIZE * FLIST_SIZE free ids
  localparam int RNID_W = 6;

  // reorder buffer credits
  localparam int ROB_SIZE = 8;
  localparam int CREDIT_W = $clog2(ROB_SIZE + 1);

  // --------------------------------------------------------------------------
  // reset constants
  // --------------------------------------------------------------------------
  // first free id sits right above the identity mapped ids
  localparam int FLIST_BASE = ARCH_REG_NUM;

  localparam logic [ARCH_REG_W-1:0] REG_X0  = '0;
  localparam logic [RNID_W-1:0]     RNID_X0 = '0;

endpackage

// File: design/rename_types_pkg.sv
package rename_types_pkg;

  // one slot of the incoming group
  typedef struct packed {
    logic                                  valid;
    logic                                  rd_valid;
    logic [rename_cfg_pkg::ARCH_REG_W-1:0] rd_regidx;
    logic                                  rs1_valid;
    logic [rename_cfg_pkg::ARCH_REG_W-1:0] rs1_regidx;
    logic                                  rs2_valid;
    logic [rename_cfg_pkg::ARCH_REG_W-1:0] rs2_regidx;
  } src_slot_t;

  // same slot after renaming
  typedef struct packed {
    logic                                  valid;
    logic                                  rd_valid;
    logic [rename_cfg_pkg::ARCH_REG_W-1:0] rd_regidx;
    logic [rename_cfg_pkg::RNID_W-1:0]     rd_rnid;
    logic [rename_cfg_pkg::RNID_W-1:0]     rd_old_rnid;
    logic                                  rs1_valid;
    logic [rename_cfg_pkg::ARCH_REG_W-1:0] rs1_regidx;
    logic [rename_cfg_pkg::RNID_W-1:0]     rs1_rnid;
    logic                                  rs2_valid;
    logic [rename_cfg_pkg::ARCH_REG_W-1:0] rs2_regidx;
    logic [rename_cfg_pkg::RNID_W-1:0]     rs2_rnid;
  } ren_slot_t;

endpackage

// File: design/rn_map_if.sv
`timescale 1ns/1ps

interface rn_map_if #(
  parameter int DISP_SIZE = rename_cfg_pkg::DISP_SIZE
);
  import rename_cfg_pkg::*;

  // source lookups, rs1 at 2*slot and rs2 at 2*slot+1
  logic [ARCH_REG_W-1:0] lookup_arch [2*DISP_SIZE];
  logic [RNID_W-1:0]     lookup_rnid [2*DISP_SIZE];

  // destination lookups for the old mapping
  logic [ARCH_REG_W-1:0] rd_arch     [DISP_SIZE];
  logic [RNID_W-1:0]     rd_old_rnid [DISP_SIZE];

  // map writes, only on a fired group
  logic [DISP_SIZE-1:0]  upd_valid;
  logic [ARCH_REG_W-1:0] upd_arch    [DISP_SIZE];
  logic [RNID_W-1:0]     upd_rnid    [DISP_SIZE];

  modport user (
    output lookup_arch, rd_arch, upd_valid, upd_arch, upd_rnid,
    input  lookup_rnid, rd_old_rnid
  );

  modport map (
    input  lookup_arch, rd_arch, upd_valid, upd_arch, upd_rnid,
    output lookup_rnid, rd_old_rnid
  );

endinterface

// File: design/free_list.sv
`timescale 1ns/1ps

module free_list #(
  parameter int FLIST_SIZE = rename_cfg_pkg::FLIST_SIZE,
  parameter int INIT_BASE  = rename_cfg_pkg::FLIST_BASE
) (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  input  logic                              i_pop,
  output logic [rename_cfg_pkg::RNID_W-1:0] o_pop_id,
  input  logic                              i_push,
  input  logic [rename_cfg_pkg::RNID_W-1:0] i_push_id
);
  import rename_cfg_pkg::*;

  localparam int PTR_W = (FLIST_SIZE > 1) ? $clog2(FLIST_SIZE) : 1;
  localparam int CNT_W = $clog2(FLIST_SIZE + 1);

  logic [RNID_W-1:0] r_ids [FLIST_SIZE];
  logic [PTR_W-1:0]  r_head;
  logic [PTR_W-1:0]  r_tail;
  logic [CNT_W-1:0]  r_count;

  // wrap for sizes that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FLIST_SIZE - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign o_pop_id = r_ids[r_head];

  // list comes out of reset full, holding this slot's id range in order
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < FLIST_SIZE; i++) begin
        r_ids[i] <= RNID_W'(INIT_BASE + i);
      end
    end else if (i_push) begin
      r_ids[r_tail] <= i_push_id;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= CNT_W'(FLIST_SIZE);
    end else begin
      if (i_pop) begin
        r_head <= ptr_inc(r_head);
      end
      if (i_push) begin
        r_tail <= ptr_inc(r_tail);
      end
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // rename side must never pop more ids than the committer gave back
  a_pop_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_pop |-> (r_count != '0))
    else $error("free_list: pop from empty list at %0t", $time);

  a_push_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_push && !i_pop) |-> (r_count != CNT_W'(FLIST_SIZE)))
    else $error("free_list: push into full list at %0t", $time);

endmodule

// File: design/rename_map.sv
`timescale 1ns/1ps

module rename_map (
  input logic   i_clk,
  input logic   i_reset_n,
  rn_map_if.map map_if
);
  import rename_cfg_pkg::*;

  logic [RNID_W-1:0] r_map [ARCH_REG_NUM];
  logic              w_x0_update;

  // --------------------------------------------------------------------------
  // combinational reads
  // --------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < $size(map_if.lookup_arch); i++) begin
      map_if.lookup_rnid[i] = r_map[map_if.lookup_arch[i]];
    end
  end

  always_comb begin
    for (int s = 0; s < $size(map_if.rd_arch); s++) begin
      map_if.rd_old_rnid[s] = r_map[map_if.rd_arch[s]];
    end
  end

  // --------------------------------------------------------------------------
  // updates
  // --------------------------------------------------------------------------
  // identity after reset; ascending slot order lets the younger slot win
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < ARCH_REG_NUM; r++) begin
        r_map[r] <= RNID_W'(r);
      end
    end else begin
      for (int s = 0; s < $size(map_if.upd_arch); s++) begin
        if (map_if.upd_valid[s] && (map_if.upd_arch[s] != REG_X0)) begin
          r_map[map_if.upd_arch[s]] <= map_if.upd_rnid[s];
        end
      end
    end
  end

  always_comb begin
    w_x0_update = 1'b0;
    for (int s = 0; s < $size(map_if.upd_arch); s++) begin
      w_x0_update |= map_if.upd_valid[s] & (map_if.upd_arch[s] == REG_X0);
    end
  end

  // bypass logic filters x0 writers before they reach the map
  a_no_x0_update: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !w_x0_update)
    else $error("rename_map: update to x0 at %0t", $time);

endmodule

// File: design/rename_bypass.sv
`timescale 1ns/1ps

module rename_bypass #(
  parameter int DISP_SIZE = rename_cfg_pkg::DISP_SIZE
) (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  input  logic                              i_fire,
  input  rename_types_pkg::src_slot_t       i_slots     [DISP_SIZE],
  input  logic [rename_cfg_pkg::RNID_W-1:0] i_new_rnid  [DISP_SIZE],
  output logic [DISP_SIZE-1:0]              o_pop,
  rn_map_if.user                            map_if,
  output logic                              o_out_valid,
  output rename_types_pkg::ren_slot_t       o_out_slots [DISP_SIZE]
);
  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  logic [DISP_SIZE-1:0] w_writes;
  logic [DISP_SIZE-1:0] w_pop;
  logic [RNID_W-1:0]    w_rd_rnid [DISP_SIZE];
  ren_slot_t            w_ren     [DISP_SIZE];

  logic                 r_out_valid;
  ren_slot_t            r_out_slots [DISP_SIZE];

  // --------------------------------------------------------------------------
  // destination allocation and map port drive
  // --------------------------------------------------------------------------
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_writes[d]  = i_slots[d].valid & i_slots[d].rd_valid &
                     (i_slots[d].rd_regidx != REG_X0);
      // x0 destinations keep rnid 0
      w_rd_rnid[d] = w_writes[d] ? i_new_rnid[d] : RNID_X0;
    end
  end

  assign w_pop = {DISP_SIZE{i_fire}} & w_writes;
  assign o_pop = w_pop;

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      map_if.lookup_arch[2*d]   = i_slots[d].rs1_regidx;
      map_if.lookup_arch[2*d+1] = i_slots[d].rs2_regidx;
      map_if.rd_arch[d]         = i_slots[d].rd_regidx;
      map_if.upd_arch[d]        = i_slots[d].rd_regidx;
      map_if.upd_rnid[d]        = w_rd_rnid[d];
    end
  end

  assign map_if.upd_valid = w_pop;

  // --------------------------------------------------------------------------
  // intra-group forwarding
  // --------------------------------------------------------------------------
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_ren[d].valid       = i_slots[d].valid;
      w_ren[d].rd_valid    = i_slots[d].rd_valid;
      w_ren[d].rd_regidx   = i_slots[d].rd_regidx;
      w_ren[d].rd_rnid     = w_rd_rnid[d];
      w_ren[d].rs1_valid   = i_slots[d].rs1_valid;
      w_ren[d].rs1_regidx  = i_slots[d].rs1_regidx;
      w_ren[d].rs2_valid   = i_slots[d].rs2_valid;
      w_ren[d].rs2_regidx  = i_slots[d].rs2_regidx;
      w_ren[d].rs1_rnid    = map_if.lookup_rnid[2*d];
      w_ren[d].rs2_rnid    = map_if.lookup_rnid[2*d+1];
      w_ren[d].rd_old_rnid = map_if.rd_old_rnid[d];
      // walk older slots upward so the nearest writer overrides
      for (int p = 0; p < d; p++) begin
        if (w_writes[p] && (i_slots[p].rd_regidx == i_slots[d].rs1_regidx)) begin
          w_ren[d].rs1_rnid = w_rd_rnid[p];
        end
        if (w_writes[p] && (i_slots[p].rd_regidx == i_slots[d].rs2_regidx)) begin
          w_ren[d].rs2_rnid = w_rd_rnid[p];
        end
        if (w_writes[p] && (i_slots[p].rd_regidx == i_slots[d].rd_regidx)) begin
          w_ren[d].rd_old_rnid = w_rd_rnid[p];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // output register
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_out_valid <= 1'b0;
    end else begin
      r_out_valid <= i_fire;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fire) begin
      r_out_slots <= w_ren;
    end
  end

  assign o_out_valid = r_out_valid;
  assign o_out_slots = r_out_slots;

endmodule

// File: design/rob_credit.sv
`timescale 1ns/1ps

module rob_credit #(
  parameter int ROB_SIZE = rename_cfg_pkg::ROB_SIZE
) (
  input  logic i_clk,
  input  logic i_reset_n,
  input  logic i_disp_valid,
  input  logic i_credit_ret,
  output logic o_ready,
  output logic o_fire
);
  import rename_cfg_pkg::*;

  logic [CREDIT_W-1:0] r_credits;

  if (ROB_SIZE >= (1 << CREDIT_W)) begin : g_size_check
    $error("rob_credit: ROB_SIZE does not fit in CREDIT_W bits");
  end

  // ready only looks at the counter, never at valid
  assign o_ready = (r_credits != '0);
  assign o_fire  = i_disp_valid & o_ready;

  // one credit per fired group, one back per return pulse
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_credits <= CREDIT_W'(ROB_SIZE);
    end else begin
      case ({o_fire, i_credit_ret})
        2'b10:   r_credits <= r_credits - 1'b1;
        2'b01:   r_credits <= r_credits + 1'b1;
        default: r_credits <= r_credits;
      endcase
    end
  end

  // committer may only return credits it was given
  a_credit_max: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_credits <= CREDIT_W'(ROB_SIZE))
    else $error("rob_credit: credit count above ROB_SIZE at %0t", $time);

endmodule

// File: design/rename_stage.sv
`timescale 1ns/1ps

module rename_stage #(
  parameter int DISP_SIZE  = rename_cfg_pkg::DISP_SIZE,
  parameter int FLIST_SIZE = rename_cfg_pkg::FLIST_SIZE,
  parameter int ROB_SIZE   = rename_cfg_pkg::ROB_SIZE
) (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,

  // incoming group
  input  logic                                  i_disp_valid,
  output logic                                  o_disp_ready,
  input  logic [DISP_SIZE-1:0]                  i_inst_valid,
  input  logic [DISP_SIZE-1:0]                  i_rd_valid,
  input  logic [rename_cfg_pkg::ARCH_REG_W-1:0] i_rd_regidx       [DISP_SIZE],
  input  logic [DISP_SIZE-1:0]                  i_rs1_valid,
  input  logic [rename_cfg_pkg::ARCH_REG_W-1:0] i_rs1_regidx      [DISP_SIZE],
  input  logic [DISP_SIZE-1:0]                  i_rs2_valid,
  input  logic [rename_cfg_pkg::ARCH_REG_W-1:0] i_rs2_regidx      [DISP_SIZE],

  // renamed group
  output logic                                  o_out_valid,
  output logic [DISP_SIZE-1:0]                  o_out_inst_valid,
  output logic [DISP_SIZE-1:0]                  o_out_rd_valid,
  output logic [rename_cfg_pkg::ARCH_REG_W-1:0] o_out_rd_regidx   [DISP_SIZE],
  output logic [rename_cfg_pkg::RNID_W-1:0]     o_out_rd_rnid     [DISP_SIZE],
  output logic [rename_cfg_pkg::RNID_W-1:0]     o_out_rd_old_rnid [DISP_SIZE],
  output logic [DISP_SIZE-1:0]                  o_out_rs1_valid,
  output logic [rename_cfg_pkg::ARCH_REG_W-1:0] o_out_rs1_regidx  [DISP_SIZE],
  output logic [rename_cfg_pkg::RNID_W-1:0]     o_out_rs1_rnid    [DISP_SIZE],
  output logic [DISP_SIZE-1:0]                  o_out_rs2_valid,
  output logic [rename_cfg_pkg::ARCH_REG_W-1:0] o_out_rs2_regidx  [DISP_SIZE],
  output logic [rename_cfg_pkg::RNID_W-1:0]     o_out_rs2_rnid    [DISP_SIZE],

  // committer returns
  input  logic [DISP_SIZE-1:0]                  i_cmt_free_valid,
  input  logic [rename_cfg_pkg::RNID_W-1:0]     i_cmt_free_rnid   [DISP_SIZE],
  input  logic                                  i_credit_ret
);
  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  logic                 w_fire;
  logic [DISP_SIZE-1:0] w_pop;
  logic [RNID_W-1:0]    w_new_rnid  [DISP_SIZE];
  src_slot_t            w_slots     [DISP_SIZE];
  ren_slot_t            w_out_slots [DISP_SIZE];

  rn_map_if #(.DISP_SIZE(DISP_SIZE)) u_map_if ();

  // --------------------------------------------------------------------------
  // port fields to slot structs and back
  // --------------------------------------------------------------------------
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_slots[d].valid      = i_inst_valid[d];
      w_slots[d].rd_valid   = i_rd_valid[d];
      w_slots[d].rd_regidx  = i_rd_regidx[d];
      w_slots[d].rs1_valid  = i_rs1_valid[d];
      w_slots[d].rs1_regidx = i_rs1_regidx[d];
      w_slots[d].rs2_valid  = i_rs2_valid[d];
      w_slots[d].rs2_regidx = i_rs2_regidx[d];
    end
  end

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_out_inst_valid[d]  = w_out_slots[d].valid;
      o_out_rd_valid[d]    = w_out_slots[d].rd_valid;
      o_out_rd_regidx[d]   = w_out_slots[d].rd_regidx;
      o_out_rd_rnid[d]     = w_out_slots[d].rd_rnid;
      o_out_rd_old_rnid[d] = w_out_slots[d].rd_old_rnid;
      o_out_rs1_valid[d]   = w_out_slots[d].rs1_valid;
      o_out_rs1_regidx[d]  = w_out_slots[d].rs1_regidx;
      o_out_rs1_rnid[d]    = w_out_slots[d].rs1_rnid;
      o_out_rs2_valid[d]   = w_out_slots[d].rs2_valid;
      o_out_rs2_regidx[d]  = w_out_slots[d].rs2_regidx;
      o_out_rs2_rnid[d]    = w_out_slots[d].rs2_rnid;
    end
  end

  // --------------------------------------------------------------------------
  // instances
  // --------------------------------------------------------------------------
  rob_credit #(.ROB_SIZE(ROB_SIZE)) u_rob_credit (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_credit_ret (i_credit_ret),
    .o_ready      (o_disp_ready),
    .o_fire       (w_fire)
  );

  // each slot owns a disjoint id range above the identity ids
  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_flist
    free_list #(
      .FLIST_SIZE (FLIST_SIZE),
      .INIT_BASE  (FLIST_BASE + FLIST_SIZE * d)
    ) u_free_list (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_pop     (w_pop[d]),
      .o_pop_id  (w_new_rnid[d]),
      .i_push    (i_cmt_free_valid[d]),
      .i_push_id (i_cmt_free_rnid[d])
    );
  end

  rename_map u_rename_map (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .map_if    (u_map_if.map)
  );

  rename_bypass #(.DISP_SIZE(DISP_SIZE)) u_rename_bypass (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_fire      (w_fire),
    .i_slots     (w_slots),
    .i_new_rnid  (w_new_rnid),
    .o_pop       (w_pop),
    .map_if      (u_map_if.user),
    .o_out_valid (o_out_valid),
    .o_out_slots (w_out_slots)
  );

endmodule

// File: tb/tb_rename_stage.sv
`timescale 1ns/1ps

module tb_rename_stage;
  import rename_cfg_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 16;
  localparam int DIRECTED_CYCLES = 64;
  localparam int RAND_GROUPS     = 120;
  // ten times the expected length of reset, directed and random parts
  localparam int MAX_CYCLES = 10 * (RESET_CYCLES + DIRECTED_CYCLES + RAND_GROUPS);

  logic                  clk;
  logic                  reset_n;
  logic                  disp_valid;
  logic                  disp_ready;
  logic [DISP_SIZE-1:0]  inst_valid, rd_valid, rs1_valid, rs2_valid;
  logic [ARCH_REG_W-1:0] rd_regidx [DISP_SIZE];
  logic [ARCH_REG_W-1:0] rs1_regidx [DISP_SIZE];
  logic [ARCH_REG_W-1:0] rs2_regidx [DISP_SIZE];
  logic                  out_valid;
  logic [DISP_SIZE-1:0]  out_inst_valid, out_rd_valid, out_rs1_valid, out_rs2_valid;
  logic [ARCH_REG_W-1:0] out_rd_regidx [DISP_SIZE];
  logic [ARCH_REG_W-1:0] out_rs1_regidx [DISP_SIZE];
  logic [ARCH_REG_W-1:0] out_rs2_regidx [DISP_SIZE];
  logic [RNID_W-1:0]     out_rd_rnid [DISP_SIZE];
  logic [RNID_W-1:0]     out_rd_old_rnid [DISP_SIZE];
  logic [RNID_W-1:0]     out_rs1_rnid [DISP_SIZE];
  logic [RNID_W-1:0]     out_rs2_rnid [DISP_SIZE];
  logic [DISP_SIZE-1:0]  cmt_free_valid;
  logic [RNID_W-1:0]     cmt_free_rnid [DISP_SIZE];
  logic                  credit_ret;

  // reference model state
  int                map_model [ARCH_REG_NUM];
  int                flist_model [DISP_SIZE][$];
  int                free_pending [DISP_SIZE][$];
  int                credit_model;
  logic              exp_fire;
  logic              chk_valid;
  logic [RNID_W-1:0] exp_rd [DISP_SIZE], exp_old [DISP_SIZE];
  logic [RNID_W-1:0] exp_rs1 [DISP_SIZE], exp_rs2 [DISP_SIZE];
  logic [RNID_W-1:0] chk_rd [DISP_SIZE], chk_old [DISP_SIZE];
  logic [RNID_W-1:0] chk_rs1 [DISP_SIZE], chk_rs2 [DISP_SIZE];
  logic [DISP_SIZE-1:0]  chk_inst_valid, chk_rd_valid, chk_rs1_valid, chk_rs2_valid;
  logic [ARCH_REG_W-1:0] chk_rd_idx [DISP_SIZE], chk_rs1_idx [DISP_SIZE];
  logic [ARCH_REG_W-1:0] chk_rs2_idx [DISP_SIZE];
  bit                auto_return, commit_en;
  int                err_value, err_ctrl, groups, cycle_cnt, seed_ret;

  rename_stage #(.DISP_SIZE(DISP_SIZE), .FLIST_SIZE(FLIST_SIZE), .ROB_SIZE(ROB_SIZE))
  u_rename_stage (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_disp_valid (disp_valid), .o_disp_ready (disp_ready),
    .i_inst_valid (inst_valid), .i_rd_valid (rd_valid), .i_rd_regidx (rd_regidx),
    .i_rs1_valid (rs1_valid), .i_rs1_regidx (rs1_regidx),
    .i_rs2_valid (rs2_valid), .i_rs2_regidx (rs2_regidx),
    .o_out_valid (out_valid), .o_out_inst_valid (out_inst_valid),
    .o_out_rd_valid (out_rd_valid), .o_out_rd_regidx (out_rd_regidx),
    .o_out_rd_rnid (out_rd_rnid), .o_out_rd_old_rnid (out_rd_old_rnid),
    .o_out_rs1_valid (out_rs1_valid), .o_out_rs1_regidx (out_rs1_regidx),
    .o_out_rs1_rnid (out_rs1_rnid), .o_out_rs2_valid (out_rs2_valid),
    .o_out_rs2_regidx (out_rs2_regidx), .o_out_rs2_rnid (out_rs2_rnid),
    .i_cmt_free_valid (cmt_free_valid), .i_cmt_free_rnid (cmt_free_rnid),
    .i_credit_ret (credit_ret)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic record_error(input bit is_ctrl, input string msg);
    if (is_ctrl) begin
      err_ctrl++;
    end else begin
      err_value++;
    end
    $display("error at %0t: %s", $time, msg);
  endtask

  // --------------------------------------------------------------------------
  // expected values move to the check registers on the fire edge
  // --------------------------------------------------------------------------
  always @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      credit_model <= ROB_SIZE;
      chk_valid    <= 1'b0;
    end else begin
      chk_valid    <= exp_fire;
      credit_model <= credit_model - int'(exp_fire) + int'(credit_ret);
      if (exp_fire) begin
        chk_rd  <= exp_rd;
        chk_old <= exp_old;
        chk_rs1 <= exp_rs1;
        chk_rs2 <= exp_rs2;
        // slot fields leave the stage unchanged
        chk_inst_valid <= inst_valid;
        chk_rd_valid   <= rd_valid;
        chk_rs1_valid  <= rs1_valid;
        chk_rs2_valid  <= rs2_valid;
        chk_rd_idx     <= rd_regidx;
        chk_rs1_idx    <= rs1_regidx;
        chk_rs2_idx    <= rs2_regidx;
      end
    end
  end

  a_ready: assert property (@(posedge clk) disable iff (!reset_n)
    disp_ready == (credit_model != 0))
    else record_error(1'b1, $sformatf("o_disp_ready is %0b with %0d credits",
                                      $sampled(disp_ready), $sampled(credit_model)));

  a_out_valid: assert property (@(posedge clk) disable iff (!reset_n)
    out_valid == chk_valid)
    else record_error(1'b1, $sformatf("o_out_valid is %0b, expected %0b",
                                      $sampled(out_valid), $sampled(chk_valid)));

  a_flags: assert property (@(posedge clk) disable iff (!reset_n)
    chk_valid |-> ({out_inst_valid, out_rd_valid, out_rs1_valid, out_rs2_valid} ==
                   {chk_inst_valid, chk_rd_valid, chk_rs1_valid, chk_rs2_valid}))
    else record_error(1'b0, $sformatf("valid flags %h, expected %h",
      $sampled({out_inst_valid, out_rd_valid, out_rs1_valid, out_rs2_valid}),
      $sampled({chk_inst_valid, chk_rd_valid, chk_rs1_valid, chk_rs2_valid})));

  for (genvar s = 0; s < DISP_SIZE; s++) begin : g_chk
    a_rd: assert property (@(posedge clk) disable iff (!reset_n)
      chk_valid |-> (out_rd_rnid[s] == chk_rd[s]))
      else record_error(1'b0, $sformatf("slot %0d rd_rnid %0d, expected %0d",
                                        s, $sampled(out_rd_rnid[s]), $sampled(chk_rd[s])));
    a_old: assert property (@(posedge clk) disable iff (!reset_n)
      chk_valid |-> (out_rd_old_rnid[s] == chk_old[s]))
      else record_error(1'b0, $sformatf("slot %0d rd_old_rnid %0d, expected %0d",
                                        s, $sampled(out_rd_old_rnid[s]), $sampled(chk_old[s])));
    a_rs1: assert property (@(posedge clk) disable iff (!reset_n)
      chk_valid |-> (out_rs1_rnid[s] == chk_rs1[s]))
      else record_error(1'b0, $sformatf("slot %0d rs1_rnid %0d, expected %0d",
                                        s, $sampled(out_rs1_rnid[s]), $sampled(chk_rs1[s])));
    a_rs2: assert property (@(posedge clk) disable iff (!reset_n)
      chk_valid |-> (out_rs2_rnid[s] == chk_rs2[s]))
      else record_error(1'b0, $sformatf("slot %0d rs2_rnid %0d, expected %0d",
                                        s, $sampled(out_rs2_rnid[s]), $sampled(chk_rs2[s])));
    a_idx: assert property (@(posedge clk) disable iff (!reset_n)
      chk_valid |-> (out_rd_regidx[s] == chk_rd_idx[s] &&
                     out_rs1_regidx[s] == chk_rs1_idx[s] &&
                     out_rs2_regidx[s] == chk_rs2_idx[s]))
      else record_error(1'b0, $sformatf("slot %0d regidx %0d/%0d/%0d, expected %0d/%0d/%0d",
        s, $sampled(out_rd_regidx[s]), $sampled(out_rs1_regidx[s]),
        $sampled(out_rs2_regidx[s]), $sampled(chk_rd_idx[s]),
        $sampled(chk_rs1_idx[s]), $sampled(chk_rs2_idx[s])));
  end

  // --------------------------------------------------------------------------
  // reference model of one fired group
  // --------------------------------------------------------------------------
  task automatic predict_group();
    bit writes [DISP_SIZE];
    int new_id [DISP_SIZE];
    for (int d = 0; d < DISP_SIZE; d++) begin
      writes[d] = inst_valid[d] && rd_valid[d] && (rd_regidx[d] != 0);
      new_id[d] = writes[d] ? flist_model[d][0] : 0;
      exp_rd[d]  = RNID_W'(new_id[d]);
      exp_rs1[d] = RNID_W'(map_model[rs1_regidx[d]]);
      exp_rs2[d] = RNID_W'(map_model[rs2_regidx[d]]);
      exp_old[d] = RNID_W'(map_model[rd_regidx[d]]);
      // nearest older writer in the group wins
      for (int p = 0; p < d; p++) begin
        if (writes[p] && rd_regidx[p] == rs1_regidx[d]) exp_rs1[d] = RNID_W'(new_id[p]);
        if (writes[p] && rd_regidx[p] == rs2_regidx[d]) exp_rs2[d] = RNID_W'(new_id[p]);
        if (writes[p] && rd_regidx[p] == rd_regidx[d]) exp_old[d] = RNID_W'(new_id[p]);
      end
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (writes[d]) begin
        map_model[rd_regidx[d]] = new_id[d];
        void'(flist_model[d].pop_front());
        if (commit_en) free_pending[d].push_back(int'(exp_old[d]));
      end
    end
  endtask

  // committer frees old ids while the list has room
  task automatic issue_commits();
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (commit_en && free_pending[d].size() != 0 && flist_model[d].size() < FLIST_SIZE) begin
        cmt_free_valid[d] = 1'b1;
        cmt_free_rnid[d]  = RNID_W'(free_pending[d].pop_front());
        flist_model[d].push_back(int'(cmt_free_rnid[d]));
      end
    end
  endtask

  task automatic send_group(input logic [ARCH_REG_W-1:0] rd0, r10, r20, rd1, r11, r21);
    bit fired;
    fired = 1'b0;
    while (!fired) begin
      @(negedge clk);
      inst_valid    = '1;
      rd_valid      = '1;
      rs1_valid     = '1;
      rs2_valid     = '1;
      rd_regidx[0]  = rd0;
      rs1_regidx[0] = r10;
      rs2_regidx[0] = r20;
      rd_regidx[1]  = rd1;
      rs1_regidx[1] = r11;
      rs2_regidx[1] = r21;
      disp_valid     = 1'b1;
      cmt_free_valid = '0;
      exp_fire       = disp_ready;
      if (auto_return) credit_ret = disp_ready;
      if (disp_ready) begin
        predict_group();
        issue_commits();
        groups++;
        fired = 1'b1;
      end
    end
  endtask

  task automatic send_rand_group();
    logic [ARCH_REG_W-1:0] r [6];
    for (int i = 0; i < 6; i++) begin
      r[i] = ARCH_REG_W'($urandom % ARCH_REG_NUM);
    end
    send_group(r[0], r[1], r[2], r[3], r[4], r[5]);
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(negedge clk);
      disp_valid     = 1'b0;
      exp_fire       = 1'b0;
      cmt_free_valid = '0;
      credit_ret     = 1'b0;
    end
  endtask

  task automatic return_credits(input int n);
    repeat (n) begin
      @(negedge clk);
      credit_ret = 1'b1;
    end
    @(negedge clk);
    credit_ret = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    seed_ret   = $urandom(32'h9a70619f);
    reset_n    = 1'b0;
    disp_valid = 1'b0;
    inst_valid = '0;
    rd_valid   = '0;
    rs1_valid  = '0;
    rs2_valid  = '0;
    credit_ret = 1'b0;
    cmt_free_valid = '0;
    exp_fire   = 1'b0;
    auto_return = 1'b0;
    commit_en  = 1'b0;
    err_value  = 0;
    err_ctrl   = 0;
    groups     = 0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      rd_regidx[d]     = '0;
      rs1_regidx[d]    = '0;
      rs2_regidx[d]    = '0;
      cmt_free_rnid[d] = '0;
      for (int i = 0; i < FLIST_SIZE; i++) begin
        flist_model[d].push_back(ARCH_REG_NUM + FLIST_SIZE * d + i);
      end
    end
    for (int r = 0; r < ARCH_REG_NUM; r++) begin
      map_model[r] = r;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    drive_idle(2);
    // first group off reset, then forwarding inside a group
    send_group(1, 2, 3, 4, 5, 6);
    send_group(7, 1, 4, 7, 7, 7);
    send_group(8, 7, 9, 9, 8, 10);
    // x0 destinations, then sources reading earlier groups
    send_group(0, 7, 8, 0, 9, 4);
    send_group(11, 0, 8, 7, 11, 0);
    drive_idle(2);
    return_credits(5);
    // drain every credit, stall, then one credit lets one group through
    repeat (ROB_SIZE) send_rand_group();
    fork
      send_rand_group();
      return_credits(4 - 3);
    join
    fork
      send_rand_group();
      begin
        repeat (3) @(negedge clk);
        return_credits(1);
      end
    join
    drive_idle(1);
    return_credits(ROB_SIZE);
    // streaming with commits, long enough to wrap both free lists
    auto_return = 1'b1;
    commit_en   = 1'b1;
    repeat (RAND_GROUPS) send_rand_group();
    drive_idle(3);
    $display("errors: value %0d, control %0d (%0d groups renamed)",
             err_value, err_ctrl, groups);
    if (err_value + err_ctrl == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: rename_stage.f
design/rename_cfg_pkg.sv
design/rename_types_pkg.sv
design/rn_map_if.sv
design/free_list.sv
design/rename_map.sv
design/rename_bypass.sv
design/rob_credit.sv
design/rename_stage.sv
tb/tb_rename_stage.sv

// File: run.sh
#!/bin/sh
# build and run the rename stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_rename_stage -f rename_stage.f -o sim_rename_stage
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_rename_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
  exit 0
fi
echo "pass message not found"
exit 1
